/* design/axi_sram_params.svh */
// Full-width INCR bursts only; DEPTH must be a power of two and BASE word aligned
`ifndef AXI_SRAM_PARAMS_SVH
`define AXI_SRAM_PARAMS_SVH

// Bus widths
`define AXI_SRAM_DATA_W 64
`define AXI_SRAM_ADDR_W 32
`define AXI_SRAM_ID_W   4

// Array geometry, depth in words
`define AXI_SRAM_DEPTH  1024
`define AXI_SRAM_BASE   32'h8000_0000

// Longest burst length field accepted without SLVERR
`define AXI_SRAM_MAX_LEN 15

`endif

/* design/axi_sram_pkg.sv */
// Shared types for the AXI SRAM slave; widths follow the params header
`default_nettype none

package axi_sram_pkg;

  `include "axi_sram_params.svh"

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } sram_op_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_e;

  typedef enum logic [1:0] {
    EX_IDLE,
    EX_READ,
    EX_WRITE
  } exec_state_e;

  // Word index into the array
  typedef logic [$clog2(`AXI_SRAM_DEPTH)-1:0] word_idx_t;

  typedef struct packed {
    sram_op_e                   op;
    logic [`AXI_SRAM_ID_W-1:0]  id;
    logic [`AXI_SRAM_DATA_W-1:0] data;
    axi_resp_e                  resp;
    logic                       last;
  } sram_beat_t;

endpackage

`default_nettype wire

/* design/axi_sram_cmd_if.sv */
// One checked command at a time; payload is only meaningful while valid is high
`timescale 1ns/1ps
`default_nettype none

`include "axi_sram_params.svh"

interface axi_sram_cmd_if
  import axi_sram_pkg::*;
();

  logic                      valid;
  logic                      ready;
  sram_op_e                  op;
  logic [`AXI_SRAM_ID_W-1:0] id;
  word_idx_t                 idx;
  logic [7:0]                len;
  logic                      err;

  // Decode side
  modport source (
    output valid, op, id, idx, len, err,
    input  ready
  );

  // Execute side
  modport sink (
    input  valid, op, id, idx, len, err,
    output ready
  );

endinterface

`default_nettype wire

/* design/axi_sram_beat_if.sv */
// Result beats in command order; write commands produce a single beat with last set
`timescale 1ns/1ps
`default_nettype none

interface axi_sram_beat_if
  import axi_sram_pkg::*;
();

  logic       valid;
  logic       ready;
  sram_beat_t beat;

  // Execute side
  modport source (
    output valid, beat,
    input  ready
  );

  // Result side whose ready depends on the beat opcode
  modport sink (
    input  valid, beat,
    output ready
  );

endinterface

`default_nettype wire

/* design/axi_sram_decode.sv */
// Read wins over write on a tie; unaligned low address bits are dropped silently
`timescale 1ns/1ps
`default_nettype none

`include "axi_sram_params.svh"

module axi_sram_decode
  import axi_sram_pkg::*;
(
  input  wire                        i_aclk,
  input  wire                        i_rst_n,

  input  wire [`AXI_SRAM_ID_W-1:0]   i_awid,
  input  wire [`AXI_SRAM_ADDR_W-1:0] i_awaddr,
  input  wire [7:0]                  i_awlen,
  input  wire [2:0]                  i_awsize,
  input  wire [1:0]                  i_awburst,
  input  wire                        i_awvalid,
  output logic                       o_awready,

  input  wire [`AXI_SRAM_ID_W-1:0]   i_arid,
  input  wire [`AXI_SRAM_ADDR_W-1:0] i_araddr,
  input  wire [7:0]                  i_arlen,
  input  wire [2:0]                  i_arsize,
  input  wire [1:0]                  i_arburst,
  input  wire                        i_arvalid,
  output logic                       o_arready,

  axi_sram_cmd_if.source             cmd
);

  localparam int unsigned BYTE_SH = $clog2(`AXI_SRAM_DATA_W / 8);
  localparam int unsigned END_W   = `AXI_SRAM_ADDR_W + 1;

  logic                        ar_fire;
  logic                        aw_fire;
  logic                        sel_read;
  logic [`AXI_SRAM_ID_W-1:0]   sel_id;
  logic [`AXI_SRAM_ADDR_W-1:0] sel_addr;
  logic [7:0]                  sel_len;
  logic [2:0]                  sel_size;
  logic [1:0]                  sel_burst;
  logic [`AXI_SRAM_ADDR_W-1:0] byte_off;
  logic [END_W-1:0]            end_word;
  logic                        sel_err;

  logic                        cmd_valid_q;
  sram_op_e                    op_q;
  logic [`AXI_SRAM_ID_W-1:0]   id_q;
  word_idx_t                   idx_q;
  logic [7:0]                  len_q;
  logic                        err_q;

  // --------------------------------------------------------------------
  // Arbitration
  // --------------------------------------------------------------------
  assign o_arready = ~cmd_valid_q;
  assign o_awready = ~cmd_valid_q & ~i_arvalid;
  assign ar_fire   = i_arvalid & o_arready;
  assign aw_fire   = i_awvalid & o_awready;
  assign sel_read  = i_arvalid;

  assign sel_id    = sel_read ? i_arid    : i_awid;
  assign sel_addr  = sel_read ? i_araddr  : i_awaddr;
  assign sel_len   = sel_read ? i_arlen   : i_awlen;
  assign sel_size  = sel_read ? i_arsize  : i_awsize;
  assign sel_burst = sel_read ? i_arburst : i_awburst;

  // --------------------------------------------------------------------
  // Request checks
  // --------------------------------------------------------------------
  assign byte_off = sel_addr - `AXI_SRAM_BASE;
  assign end_word = {1'b0, byte_off >> BYTE_SH} + END_W'(sel_len);

  assign sel_err = (sel_burst != BURST_INCR) |
                   (sel_size != 3'(BYTE_SH)) |
                   (sel_len > 8'(`AXI_SRAM_MAX_LEN)) |
                   (sel_addr < `AXI_SRAM_BASE) |
                   (end_word >= END_W'(`AXI_SRAM_DEPTH));

  // Held until execute takes it
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cmd_valid_q <= 1'b0;
    end else if (ar_fire | aw_fire) begin
      cmd_valid_q <= 1'b1;
    end else if (cmd.ready) begin
      cmd_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (ar_fire | aw_fire) begin
      op_q  <= sel_read ? OP_READ : OP_WRITE;
      id_q  <= sel_id;
      idx_q <= word_idx_t'(byte_off >> BYTE_SH);
      len_q <= sel_len;
      err_q <= sel_err;
    end
  end

  assign cmd.valid = cmd_valid_q;
  assign cmd.op    = op_q;
  assign cmd.id    = id_q;
  assign cmd.idx   = idx_q;
  assign cmd.len   = len_q;
  assign cmd.err   = err_q;

endmodule

`default_nettype wire

/* design/axi_sram_execute.sv */
// One command at a time; wlast is not checked, the burst length sets the W beat count
`timescale 1ns/1ps
`default_nettype none

`include "axi_sram_params.svh"

module axi_sram_execute
  import axi_sram_pkg::*;
(
  input  wire                          i_aclk,
  input  wire                          i_rst_n,

  axi_sram_cmd_if.sink                 cmd,

  input  wire [`AXI_SRAM_DATA_W-1:0]   i_wdata,
  input  wire [`AXI_SRAM_DATA_W/8-1:0] i_wstrb,
  input  wire                          i_wvalid,
  output logic                         o_wready,

  axi_sram_beat_if.source              beat
);

  localparam int unsigned STRB_W = `AXI_SRAM_DATA_W / 8;

  logic [`AXI_SRAM_DATA_W-1:0] mem [`AXI_SRAM_DEPTH];

  exec_state_e               state_q;
  logic [7:0]                cnt_q;
  word_idx_t                 idx_q;
  logic                      wr_done_q;
  logic [`AXI_SRAM_ID_W-1:0] id_q;
  logic                      err_q;
  logic                      beat_valid_q;
  sram_beat_t                beat_q;

  logic                      cmd_fire;
  logic                      w_fire;
  logic                      beat_free;
  logic                      rd_step;
  logic                      wr_resp;

  // Beat slot can be refilled in the cycle it drains
  assign beat_free = ~beat_valid_q | beat.ready;

  assign cmd.ready = (state_q == EX_IDLE);
  assign cmd_fire  = cmd.valid & cmd.ready;
  assign o_wready  = (state_q == EX_WRITE) & ~wr_done_q;
  assign w_fire    = i_wvalid & o_wready;
  assign rd_step   = (state_q == EX_READ) & beat_free;
  assign wr_resp   = (state_q == EX_WRITE) & wr_done_q & beat_free;

  // --------------------------------------------------------------------
  // Burst control
  // --------------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q   <= EX_IDLE;
      cnt_q     <= 8'd0;
      idx_q     <= '0;
      wr_done_q <= 1'b0;
    end else begin
      case (state_q)
        EX_IDLE: begin
          if (cmd_fire) begin
            state_q   <= (cmd.op == OP_READ) ? EX_READ : EX_WRITE;
            cnt_q     <= cmd.len;
            idx_q     <= cmd.idx;
            wr_done_q <= 1'b0;
          end
        end
        EX_READ: begin
          if (rd_step) begin
            cnt_q <= cnt_q - 8'd1;
            idx_q <= idx_q + 1'b1;
            if (cnt_q == 8'd0) begin
              state_q <= EX_IDLE;
            end
          end
        end
        EX_WRITE: begin
          if (w_fire) begin
            cnt_q <= cnt_q - 8'd1;
            idx_q <= idx_q + 1'b1;
            if (cnt_q == 8'd0) begin
              wr_done_q <= 1'b1;
            end
          end else if (wr_resp) begin
            wr_done_q <= 1'b0;
            state_q   <= EX_IDLE;
          end
        end
        default: begin
          state_q <= EX_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      beat_valid_q <= 1'b0;
    end else if (rd_step | wr_resp) begin
      beat_valid_q <= 1'b1;
    end else if (beat.ready) begin
      beat_valid_q <= 1'b0;
    end
  end

  // --------------------------------------------------------------------
  // Array access and beat payload
  // --------------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (cmd_fire) begin
      id_q  <= cmd.id;
      err_q <= cmd.err;
    end

    if (rd_step | wr_resp) begin
      beat_q.op   <= rd_step ? OP_READ : OP_WRITE;
      beat_q.id   <= id_q;
      beat_q.resp <= err_q ? RESP_SLVERR : RESP_OKAY;
      beat_q.last <= wr_resp | (cnt_q == 8'd0);
      // Errored reads return zero data
      beat_q.data <= (rd_step && !err_q) ? mem[idx_q] : '0;
    end

    if (w_fire && !err_q) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (i_wstrb[b]) begin
          mem[idx_q][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  assign beat.valid = beat_valid_q;
  assign beat.beat  = beat_q;

endmodule

`default_nettype wire

/* design/axi_sram_result.sv */
// R and B are single registered slots; o_rlast and the payloads hold stale values while invalid
`timescale 1ns/1ps
`default_nettype none

`include "axi_sram_params.svh"

module axi_sram_result
  import axi_sram_pkg::*;
(
  input  wire                         i_aclk,
  input  wire                         i_rst_n,

  axi_sram_beat_if.sink               beat,

  output logic [`AXI_SRAM_ID_W-1:0]   o_bid,
  output logic [1:0]                  o_bresp,
  output logic                        o_bvalid,
  input  wire                         i_bready,

  output logic [`AXI_SRAM_ID_W-1:0]   o_rid,
  output logic [`AXI_SRAM_DATA_W-1:0] o_rdata,
  output logic [1:0]                  o_rresp,
  output logic                        o_rlast,
  output logic                        o_rvalid,
  input  wire                         i_rready
);

  logic                        r_valid_q;
  logic [`AXI_SRAM_ID_W-1:0]   r_id_q;
  logic [`AXI_SRAM_DATA_W-1:0] r_data_q;
  axi_resp_e                   r_resp_q;
  logic                        r_last_q;

  logic                        b_valid_q;
  logic [`AXI_SRAM_ID_W-1:0]   b_id_q;
  axi_resp_e                   b_resp_q;

  logic                        to_read;
  logic                        r_free;
  logic                        b_free;
  logic                        load_r;
  logic                        load_b;

  // Slot is free when empty or draining this cycle
  assign r_free  = ~r_valid_q | i_rready;
  assign b_free  = ~b_valid_q | i_bready;
  assign to_read = (beat.beat.op == OP_READ);

  assign beat.ready = to_read ? r_free : b_free;
  assign load_r     = beat.valid & beat.ready & to_read;
  assign load_b     = beat.valid & beat.ready & ~to_read;

  // --------------------------------------------------------------------
  // Valid flags
  // --------------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_valid_q <= 1'b0;
      b_valid_q <= 1'b0;
    end else begin
      if (load_r) begin
        r_valid_q <= 1'b1;
      end else if (i_rready) begin
        r_valid_q <= 1'b0;
      end
      if (load_b) begin
        b_valid_q <= 1'b1;
      end else if (i_bready) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  // Payload registers
  always_ff @(posedge i_aclk) begin
    if (load_r) begin
      r_id_q   <= beat.beat.id;
      r_data_q <= beat.beat.data;
      r_resp_q <= beat.beat.resp;
      r_last_q <= beat.beat.last;
    end
    if (load_b) begin
      b_id_q   <= beat.beat.id;
      b_resp_q <= beat.beat.resp;
    end
  end

  assign o_rvalid = r_valid_q;
  assign o_rid    = r_id_q;
  assign o_rdata  = r_data_q;
  assign o_rresp  = r_resp_q;
  assign o_rlast  = r_last_q;

  assign o_bvalid = b_valid_q;
  assign o_bid    = b_id_q;
  assign o_bresp  = b_resp_q;

endmodule

`default_nettype wire

/* design/axi_sram_top.sv */
// AXI4 slave over on-chip SRAM; lock, cache, prot and wlast are accepted but ignored
`timescale 1ns/1ps
`default_nettype none

`include "axi_sram_params.svh"

module axi_sram_top (
  input  wire                          i_aclk,
  input  wire                          i_rst_n,

  // Write address
  input  wire [`AXI_SRAM_ID_W-1:0]     i_awid,
  input  wire [`AXI_SRAM_ADDR_W-1:0]   i_awaddr,
  input  wire [7:0]                    i_awlen,
  input  wire [2:0]                    i_awsize,
  input  wire [1:0]                    i_awburst,
  input  wire [1:0]                    i_awlock,
  input  wire [3:0]                    i_awcache,
  input  wire [2:0]                    i_awprot,
  input  wire                          i_awvalid,
  output logic                         o_awready,

  // Write data
  input  wire [`AXI_SRAM_DATA_W-1:0]   i_wdata,
  input  wire [`AXI_SRAM_DATA_W/8-1:0] i_wstrb,
  input  wire                          i_wlast,
  input  wire                          i_wvalid,
  output logic                         o_wready,

  // Write response
  output logic [`AXI_SRAM_ID_W-1:0]    o_bid,
  output logic [1:0]                   o_bresp,
  output logic                         o_bvalid,
  input  wire                          i_bready,

  // Read address
  input  wire [`AXI_SRAM_ID_W-1:0]     i_arid,
  input  wire [`AXI_SRAM_ADDR_W-1:0]   i_araddr,
  input  wire [7:0]                    i_arlen,
  input  wire [2:0]                    i_arsize,
  input  wire [1:0]                    i_arburst,
  input  wire [1:0]                    i_arlock,
  input  wire [3:0]                    i_arcache,
  input  wire [2:0]                    i_arprot,
  input  wire                          i_arvalid,
  output logic                         o_arready,

  // Read data
  output logic [`AXI_SRAM_ID_W-1:0]    o_rid,
  output logic [`AXI_SRAM_DATA_W-1:0]  o_rdata,
  output logic [1:0]                   o_rresp,
  output logic                         o_rlast,
  output logic                         o_rvalid,
  input  wire                          i_rready
);

  axi_sram_cmd_if  u_cmd_if ();
  axi_sram_beat_if u_beat_if ();

  axi_sram_decode u_decode (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_awid    (i_awid),
    .i_awaddr  (i_awaddr),
    .i_awlen   (i_awlen),
    .i_awsize  (i_awsize),
    .i_awburst (i_awburst),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_arid    (i_arid),
    .i_araddr  (i_araddr),
    .i_arlen   (i_arlen),
    .i_arsize  (i_arsize),
    .i_arburst (i_arburst),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .cmd       (u_cmd_if)
  );

  axi_sram_execute u_execute (
    .i_aclk   (i_aclk),
    .i_rst_n  (i_rst_n),
    .cmd      (u_cmd_if),
    .i_wdata  (i_wdata),
    .i_wstrb  (i_wstrb),
    .i_wvalid (i_wvalid),
    .o_wready (o_wready),
    .beat     (u_beat_if)
  );

  axi_sram_result u_result (
    .i_aclk   (i_aclk),
    .i_rst_n  (i_rst_n),
    .beat     (u_beat_if),
    .o_bid    (o_bid),
    .o_bresp  (o_bresp),
    .o_bvalid (o_bvalid),
    .i_bready (i_bready),
    .o_rid    (o_rid),
    .o_rdata  (o_rdata),
    .o_rresp  (o_rresp),
    .o_rlast  (o_rlast),
    .o_rvalid (o_rvalid),
    .i_rready (i_rready)
  );

endmodule

`default_nettype wire

/* tb/axi_sram_tb.sv */
// Reads only cover words written earlier in the run as the SRAM has no reset; 64-bit data assumed
`timescale 1ns/1ps
`default_nettype none

`include "axi_sram_params.svh"

module axi_sram_tb
  import axi_sram_pkg::*;
();

  localparam int unsigned DATA_W  = `AXI_SRAM_DATA_W;
  localparam int unsigned STRB_W  = DATA_W / 8;
  localparam int unsigned ID_W    = `AXI_SRAM_ID_W;
  localparam int unsigned BYTE_SH = $clog2(STRB_W);
  localparam logic [31:0] BASE    = `AXI_SRAM_BASE;
  localparam logic [31:0] SEED    = 32'h7192;
  localparam logic [2:0]  FULL    = 3'(BYTE_SH);

  typedef struct packed {
    sram_op_e          op;
    logic [ID_W-1:0]   id;
    logic [31:0]       addr;
    logic [7:0]        len;
    axi_burst_e        burst;
    logic [2:0]        size;
    logic [31:0]       seed;
    logic [STRB_W-1:0] strb;
    axi_resp_e         resp;
    logic              with_next;
  } stim_entry_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } w_beat_t;

  logic                        i_aclk;
  logic                        i_rst_n;
  logic [ID_W-1:0]             i_awid;
  logic [`AXI_SRAM_ADDR_W-1:0] i_awaddr;
  logic [7:0]                  i_awlen;
  logic [2:0]                  i_awsize;
  logic [1:0]                  i_awburst;
  logic [1:0]                  i_awlock;
  logic [3:0]                  i_awcache;
  logic [2:0]                  i_awprot;
  logic                        i_awvalid;
  logic                        o_awready;
  logic [DATA_W-1:0]           i_wdata;
  logic [STRB_W-1:0]           i_wstrb;
  logic                        i_wlast;
  logic                        i_wvalid;
  logic                        o_wready;
  logic [ID_W-1:0]             o_bid;
  logic [1:0]                  o_bresp;
  logic                        o_bvalid;
  logic                        i_bready;
  logic [ID_W-1:0]             i_arid;
  logic [`AXI_SRAM_ADDR_W-1:0] i_araddr;
  logic [7:0]                  i_arlen;
  logic [2:0]                  i_arsize;
  logic [1:0]                  i_arburst;
  logic [1:0]                  i_arlock;
  logic [3:0]                  i_arcache;
  logic [2:0]                  i_arprot;
  logic                        i_arvalid;
  logic                        o_arready;
  logic [ID_W-1:0]             o_rid;
  logic [DATA_W-1:0]           o_rdata;
  logic [1:0]                  o_rresp;
  logic                        o_rlast;
  logic                        o_rvalid;
  logic                        i_rready;

  logic [DATA_W-1:0] ref_mem [`AXI_SRAM_DEPTH];
  stim_entry_t       stim_table [$];
  w_beat_t           w_q [$];
  sram_beat_t        exp_r_q [$];
  sram_beat_t        exp_b_q [$];
  logic [31:0]       lcg_state;
  logic              pair_next;
  int unsigned       cycle_cnt = 0;
  int unsigned       cycle_limit;
  int unsigned       ent;

  axi_sram_top i_dut (.*);

  always #5 i_aclk = ~i_aclk;

  // --------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [DATA_W-1:0] beat_data(input logic [31:0] seed, input int unsigned b);
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next(SEED ^ (seed + b));
    lo = lcg_next(hi);
    return {hi, lo};
  endfunction

  // Strobe rotates left one byte per beat
  function automatic logic [STRB_W-1:0] rot_strb(input logic [STRB_W-1:0] s, input int unsigned n);
    logic [2*STRB_W-1:0] t;
    t = {s, s} << (n % STRB_W);
    return t[2*STRB_W-1 -: STRB_W];
  endfunction

  function automatic bit group_done();
    return !i_awvalid && !i_arvalid && (w_q.size() == 0) &&
           (exp_r_q.size() == 0) && (exp_b_q.size() == 0);
  endfunction

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // --------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------
  task automatic check_resp(input string sig, input axi_resp_e got, input axi_resp_e exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED %s: got %h expected %h", sig, got, exp));
    end
  endtask

  task automatic check_data(input string sig, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED %s: got %h expected %h", sig, got, exp));
    end
  endtask

  task automatic check_id(input string sig, input logic [ID_W-1:0] got,
                          input logic [ID_W-1:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED %s: got %h expected %h", sig, got, exp));
    end
  endtask

  task automatic check_last(input string sig, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED %s: got %h expected %h", sig, got, exp));
    end
  endtask

  // Address is a byte offset from the array base
  task automatic add_entry(input sram_op_e op, input logic [ID_W-1:0] id,
                           input logic [31:0] off, input logic [7:0] len,
                           input axi_burst_e burst, input logic [2:0] size,
                           input logic [31:0] seed, input logic [STRB_W-1:0] strb,
                           input axi_resp_e resp);
    stim_entry_t e;
    e.op        = op;
    e.id        = id;
    e.addr      = BASE + off;
    e.len       = len;
    e.burst     = burst;
    e.size      = size;
    e.seed      = seed;
    e.strb      = strb;
    e.resp      = resp;
    e.with_next = pair_next;
    pair_next   = 1'b0;
    stim_table.push_back(e);
  endtask

  task automatic load_table();
    // Single beat write and read back
    add_entry(OP_WRITE, 4'h3, 32'h0040, 8'd0, BURST_INCR, FULL, 32'h011, 8'hff, RESP_OKAY);
    add_entry(OP_READ, 4'h5, 32'h0040, 8'd0, BURST_INCR, FULL, 32'h000, 8'h00, RESP_OKAY);
    // Eight beat full write then strobed overlay
    add_entry(OP_WRITE, 4'h1, 32'h0100, 8'd7, BURST_INCR, FULL, 32'h200, 8'hff, RESP_OKAY);
    add_entry(OP_WRITE, 4'h2, 32'h0100, 8'd7, BURST_INCR, FULL, 32'h300, 8'h5a, RESP_OKAY);
    add_entry(OP_READ, 4'h4, 32'h0100, 8'd7, BURST_INCR, FULL, 32'h000, 8'h00, RESP_OKAY);
    // Burst running past the top of the array
    add_entry(OP_WRITE, 4'h6, 32'h1fe0, 8'd3, BURST_INCR, FULL, 32'h400, 8'hff, RESP_OKAY);
    add_entry(OP_WRITE, 4'h7, 32'h1fe0, 8'd7, BURST_INCR, FULL, 32'h500, 8'hff, RESP_SLVERR);
    add_entry(OP_READ, 4'h8, 32'h1fe0, 8'd3, BURST_INCR, FULL, 32'h000, 8'h00, RESP_OKAY);
    // Unsupported type, size, length and address
    add_entry(OP_READ, 4'h9, 32'h0100, 8'd3, BURST_WRAP, FULL, 32'h000, 8'h00, RESP_SLVERR);
    add_entry(OP_READ, 4'ha, 32'h0100, 8'd2, BURST_INCR, 3'd2, 32'h000, 8'h00, RESP_SLVERR);
    add_entry(OP_READ, 4'hb, 32'h0040, 8'd16, BURST_INCR, FULL, 32'h000, 8'h00, RESP_SLVERR);
    add_entry(OP_READ, 4'hc, 32'h2000, 8'd0, BURST_INCR, FULL, 32'h000, 8'h00, RESP_SLVERR);
    // Mixed traffic under stalls
    add_entry(OP_WRITE, 4'hd, 32'h0800, 8'd15, BURST_INCR, FULL, 32'h600, 8'hff, RESP_OKAY);
    add_entry(OP_READ, 4'he, 32'h0800, 8'd15, BURST_INCR, FULL, 32'h000, 8'h00, RESP_OKAY);
    add_entry(OP_WRITE, 4'hf, 32'h0808, 8'd3, BURST_INCR, FULL, 32'h700, 8'h81, RESP_OKAY);
    add_entry(OP_READ, 4'h0, 32'h0800, 8'd15, BURST_INCR, FULL, 32'h000, 8'h00, RESP_OKAY);
    // AR and AW in the same cycle where the read sees the old word
    pair_next = 1'b1;
    add_entry(OP_READ, 4'h1, 32'h0040, 8'd0, BURST_INCR, FULL, 32'h000, 8'h00, RESP_OKAY);
    add_entry(OP_WRITE, 4'h2, 32'h0040, 8'd0, BURST_INCR, FULL, 32'h800, 8'hff, RESP_OKAY);
    add_entry(OP_READ, 4'h3, 32'h0040, 8'd0, BURST_INCR, FULL, 32'h000, 8'h00, RESP_OKAY);
  endtask

  // Queues the beats and expected responses of one entry
  task automatic issue_entry(input stim_entry_t e);
    int unsigned       word;
    int unsigned       nb;
    int unsigned       b;
    int unsigned       k;
    word_idx_t         widx;
    logic [DATA_W-1:0] d;
    logic [STRB_W-1:0] s;
    w_beat_t           wb;
    sram_beat_t        exp;
    word     = 32'((e.addr - BASE) >> BYTE_SH);
    nb       = 32'(e.len) + 1;
    exp.op   = e.op;
    exp.id   = e.id;
    exp.resp = e.resp;
    exp.data = '0;
    exp.last = 1'b1;
    if (e.op == OP_WRITE) begin
      i_awid    = e.id;
      i_awaddr  = e.addr;
      i_awlen   = e.len;
      i_awsize  = e.size;
      i_awburst = e.burst;
      i_awvalid = 1'b1;
      for (b = 0; b < nb; b++) begin
        d       = beat_data(e.seed, b);
        s       = rot_strb(e.strb, b);
        wb.data = d;
        wb.strb = s;
        wb.last = (b == nb - 1);
        w_q.push_back(wb);
        if (e.resp == RESP_OKAY) begin
          widx = word_idx_t'(word + b);
          for (k = 0; k < STRB_W; k++) begin
            if (s[k]) begin
              ref_mem[widx][k*8 +: 8] = d[k*8 +: 8];
            end
          end
        end
      end
      exp_b_q.push_back(exp);
    end else begin
      i_arid    = e.id;
      i_araddr  = e.addr;
      i_arlen   = e.len;
      i_arsize  = e.size;
      i_arburst = e.burst;
      i_arvalid = 1'b1;
      for (b = 0; b < nb; b++) begin
        widx     = word_idx_t'(word + b);
        exp.data = (e.resp == RESP_OKAY) ? ref_mem[widx] : '0;
        exp.last = (b == nb - 1);
        exp_r_q.push_back(exp);
      end
    end
  endtask

  task automatic drive_w();
    if (w_q.size() > 0) begin
      i_wvalid = 1'b1;
      i_wdata  = w_q[0].data;
      i_wstrb  = w_q[0].strb;
      i_wlast  = w_q[0].last;
    end else begin
      i_wvalid = 1'b0;
    end
  endtask

  // --------------------------------------------------------------------
  // Sample at the falling edge and drive after the rising edge
  // --------------------------------------------------------------------
  task automatic step_cycle();
    logic       aw_hs;
    logic       ar_hs;
    logic       w_hs;
    logic       r_hs;
    logic       b_hs;
    sram_beat_t exp;
    @(negedge i_aclk);
    aw_hs = i_awvalid & o_awready;
    ar_hs = i_arvalid & o_arready;
    w_hs  = i_wvalid & o_wready;
    r_hs  = o_rvalid & i_rready;
    b_hs  = o_bvalid & i_bready;
    if (r_hs) begin
      if (exp_r_q.size() == 0) begin
        stop_on_error("A read beat came back with no read outstanding");
      end else begin
        exp = exp_r_q.pop_front();
        check_id("o_rid", o_rid, exp.id);
        check_data("o_rdata", o_rdata, exp.data);
        check_resp("o_rresp", axi_resp_e'(o_rresp), exp.resp);
        check_last("o_rlast", o_rlast, exp.last);
      end
    end
    if (b_hs) begin
      if (exp_b_q.size() == 0) begin
        stop_on_error("A write response came back with no write outstanding");
      end else begin
        exp = exp_b_q.pop_front();
        check_id("o_bid", o_bid, exp.id);
        check_resp("o_bresp", axi_resp_e'(o_bresp), exp.resp);
      end
    end
    @(posedge i_aclk);
    #1;
    if (aw_hs) begin
      i_awvalid = 1'b0;
    end
    if (ar_hs) begin
      i_arvalid = 1'b0;
    end
    if (w_hs) begin
      w_q.delete(0);
    end
    drive_w();
    lcg_state = lcg_next(lcg_state);
    i_rready  = (lcg_state[17:16] != 2'b00);
    lcg_state = lcg_next(lcg_state);
    i_bready  = (lcg_state[19:18] != 2'b00);
  endtask

  always @(posedge i_aclk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      stop_on_error("Timeout: the DUT did not finish the transactions in time");
    end
  end

  initial begin
    i_aclk    = 1'b0;
    i_rst_n   = 1'b0;
    i_awid    = '0;
    i_awaddr  = '0;
    i_awlen   = '0;
    i_awsize  = '0;
    i_awburst = '0;
    i_awlock  = '0;
    i_awcache = '0;
    i_awprot  = '0;
    i_awvalid = 1'b0;
    i_wdata   = '0;
    i_wstrb   = '0;
    i_wlast   = 1'b0;
    i_wvalid  = 1'b0;
    i_bready  = 1'b0;
    i_arid    = '0;
    i_araddr  = '0;
    i_arlen   = '0;
    i_arsize  = '0;
    i_arburst = '0;
    i_arlock  = '0;
    i_arcache = '0;
    i_arprot  = '0;
    i_arvalid = 1'b0;
    i_rready  = 1'b0;
    lcg_state = SEED;
    pair_next = 1'b0;
    load_table();
    cycle_limit = 16 + 32 + 64 * stim_table.size();

    repeat (16) @(posedge i_aclk);
    #1;
    i_rst_n = 1'b1;
    if (o_awready !== 1'b1 || o_arready !== 1'b1 || o_wready !== 1'b0 ||
        o_bvalid !== 1'b0 || o_rvalid !== 1'b0) begin
      stop_on_error("Handshake outputs are not at their reset values");
    end

    ent = 0;
    while (ent < stim_table.size()) begin
      issue_entry(stim_table[ent]);
      while (stim_table[ent].with_next && (ent + 1 < stim_table.size())) begin
        ent++;
        issue_entry(stim_table[ent]);
      end
      ent++;
      drive_w();
      while (!group_done()) begin
        step_cycle();
      end
    end

    // Idle cycles catch duplicated beats
    repeat (20) step_cycle();

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+design
design/axi_sram_pkg.sv
design/axi_sram_cmd_if.sv
design/axi_sram_beat_if.sv
design/axi_sram_decode.sv
design/axi_sram_execute.sv
design/axi_sram_result.sv
design/axi_sram_top.sv
tb/axi_sram_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= axi_sram_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
